// File: build.f
+incdir+.
mmio_pkg.sv
uart_if.sv
uart.sv
io_regs.sv
mmio_top.sv
mmio_props.sv
tb_mmio.sv

// File: tb_mmio.sv
// MMIO block testbench
`timescale 1ns/1ns
`include "mmio_macros.svh"

module tb_mmio;
	import mmio_pkg::*;

	localparam int NUM_BYTES = 20;
	localparam int FRAME_CYCLES = 10 * `UART_BIT_CYCLES;
	localparam int LIMIT_CYCLES = NUM_BYTES * 12 * FRAME_CYCLES + 4000;

	logic Clock = 1'b0;
	logic rst_n, psel, penable, pwrite, stall, line_ready;
	word_t paddr, pwdata, prdata;
	logic pready, pslverr;
	wire uart_loop;
	point_t le_point;
	color_t le_color, fill_color;
	logic le_color_valid, le_x0_valid, le_y0_valid, le_x1_valid, le_y1_valid;
	logic le_trigger, fill_valid;

	integer seed;
	word_t model_cycles = '0;
	word_t model_instr = '0;
	word_t snap_cycles, snap_instr;
	logic [5:0] exp_stb [$];
	logic exp_trig [$];
	color_t exp_data [$];
	logic [5:0] mon_stb, mon_exp;
	color_t mon_data;
	logic [7:0] cmd_offs [10] = '{`REG_X0, `REG_Y0, `REG_X1, `REG_Y1, `REG_X0_GO,
		`REG_Y0_GO, `REG_X1_GO, `REG_Y1_GO, `REG_LE_COLOR, `REG_FILL};

	mmio_top mmio_top_i (
		.Clock, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr, .stall, .line_ready,
		.uart_sin(uart_loop), .uart_sout(uart_loop),
		.le_point, .le_color, .le_color_valid,
		.le_x0_valid, .le_y0_valid, .le_x1_valid, .le_y1_valid,
		.le_trigger, .fill_color, .fill_valid
	);

	always #20 Clock = ~Clock;

	// Counter model over all edges and non-stalled edges
	always @(posedge Clock)
	begin
		model_cycles <= model_cycles + 32'd1;
		if (!stall)
			model_instr <= model_instr + 32'd1;
	end

	initial
	begin
		#(LIMIT_CYCLES * 40);
		$display("timeout after %0d cycles, a transfer or the UART hung", LIMIT_CYCLES);
		$display("*** FAILED ***");
		$fatal(1, "watchdog expired");
	end

	always @(mmio_top_i.mmio_props_i.fail_count)
	begin
		if (mmio_top_i.mmio_props_i.fail_count != 0)
		begin
			$display("bound assertion failed at %0t ns", $time);
			$display("*** FAILED ***");
			$fatal(1, "assertion failure");
		end
	end

	function automatic word_t reg_addr(input logic [7:0] off);
		return `IO_BASE | word_t'(off);
	endfunction

	task automatic check(input logic [31:0] actual, input logic [31:0] expected,
		input string msg);
		if (actual !== expected)
		begin
			$display("mismatch at %0t ns: %s, got %h, expected %h", $time, msg, actual, expected);
			$display("*** FAILED ***");
			$fatal(1, "run stopped at first error");
		end
	endtask

	// Called and returns 5 ns after a rising edge
	task apb_write(input word_t addr, input word_t data, output logic err, output int waits);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(posedge Clock);
		#5 penable = 1'b1;
		waits = 0;
		@(negedge Clock);
		while (!pready)
		begin
			waits++;
			@(negedge Clock);
		end
		err = pslverr;
		@(posedge Clock);
		#5 psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task apb_read(input word_t addr, output word_t data, output logic err);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = addr;
		@(posedge Clock);
		#5 penable = 1'b1;
		@(negedge Clock);
		while (!pready)
			@(negedge Clock);
		data = prdata;
		err = pslverr;
		snap_cycles = model_cycles;
		snap_instr = model_instr;
		@(posedge Clock);
		#5 psel = 1'b0;
		penable = 1'b0;
	endtask

	task recv_byte(output byte_t data);
		word_t rd;
		logic err;
		rd = '0;
		while (!rd[1])
			apb_read(reg_addr(`REG_UART_STAT), rd, err);
		apb_read(reg_addr(`REG_UART_RX), rd, err);
		check(err, 1'b0, "pslverr on RX read");
		data = rd[7:0];
	endtask

	// Strobe vector order is fill, color, y1, x1, y0, x0
	task expect_command(input logic [7:0] off, input word_t data);
		case (off)
			`REG_X0, `REG_X0_GO: exp_stb.push_back(6'b000001);
			`REG_Y0, `REG_Y0_GO: exp_stb.push_back(6'b000010);
			`REG_X1, `REG_X1_GO: exp_stb.push_back(6'b000100);
			`REG_Y1, `REG_Y1_GO: exp_stb.push_back(6'b001000);
			`REG_LE_COLOR: exp_stb.push_back(6'b010000);
			default: exp_stb.push_back(6'b100000);
		endcase
		exp_trig.push_back(off >= `REG_X0_GO);
		exp_data.push_back(data[23:0]);
	endtask

	// ----------------------------------------
	// Line engine and fill monitor
	// ----------------------------------------
	always @(negedge Clock)
	begin
		mon_stb = {fill_valid, le_color_valid, le_y1_valid, le_x1_valid, le_y0_valid, le_x0_valid};
		if (rst_n && (mon_stb != 6'd0 || le_trigger))
		begin
			if (exp_stb.size() == 0)
			begin
				$display("command strobe %b at %0t ns with no write pending", mon_stb, $time);
				$display("*** FAILED ***");
				$fatal(1, "extra command strobe");
			end
			else
			begin
				mon_exp = exp_stb.pop_front();
				mon_data = exp_data.pop_front();
				check(mon_stb, mon_exp, "command strobe");
				check(le_trigger, exp_trig.pop_front(), "le_trigger");
				if (mon_exp[5])
					check(fill_color, mon_data, "fill color");
				else if (mon_exp[4])
					check(le_color, mon_data, "line color");
				else
					check(le_point, mon_data[9:0], "line point");
			end
		end
	end

	initial
	begin
		word_t rd;
		logic err;
		int waits;
		int n;
		logic [7:0] off;
		byte_t b0, b1, got;
		seed = 32'hf5dc_0e10;
		rst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		stall = 1'b0;
		line_ready = 1'b0;
		repeat (10) @(posedge Clock);
		#5 rst_n = 1'b1;

		// Error responses
		apb_read(reg_addr(`REG_UART_RX), rd, err);
		check(err, 1'b1, "pslverr on empty RX read");
		check(rd, 0, "prdata on empty RX read");
		apb_read(reg_addr(8'h50), rd, err);
		check(err, 1'b1, "pslverr on undefined offset");
		check(rd, 0, "prdata on undefined offset");
		apb_write(32'h9000_0000 | word_t'(`REG_FILL), 32'h00ab_cdef, err, waits);
		check(err, 1'b1, "pslverr outside block base");
		repeat (6)
		begin
			line_ready = $random(seed);
			apb_read(reg_addr(`REG_LINE_STAT), rd, err);
			check(err, 1'b0, "pslverr on line status");
			check(rd, {31'd0, line_ready}, "line status");
		end

		// ----------------------------------------
		// Line engine and fill commands
		// ----------------------------------------
		repeat (60)
		begin
			off = cmd_offs[$unsigned($random(seed)) % 10];
			rd = $random(seed);
			expect_command(off, rd);
			apb_write(reg_addr(off), rd, err, waits);
			check(err, 1'b0, "pslverr on command write");
			// Strobe due in the cycle after the completing edge
			@(posedge Clock);
			#5 check(exp_stb.size(), 0, "command strobe one cycle after the write");
		end

		// Counters from a clear under random stall
		repeat (4)
		begin
			apb_write(reg_addr(`REG_CNT_CLR), $random(seed), err, waits);
			model_cycles = '0;
			model_instr = '0;
			n = 4 + $unsigned($random(seed)) % 60;
			repeat (n)
			begin
				stall = $random(seed);
				@(posedge Clock);
				#5;
			end
			apb_read(reg_addr(`REG_CYCLES), rd, err);
			check(rd, snap_cycles, "cycle counter");
			apb_read(reg_addr(`REG_INSTR), rd, err);
			check(rd, snap_instr, "instruction counter");
		end
		stall = 1'b0;

		// ----------------------------------------
		// UART loopback in pairs of back-to-back writes
		// ----------------------------------------
		for (int i = 0; i < NUM_BYTES / 2; i++)
		begin
			b0 = $random(seed);
			b1 = $random(seed);
			apb_write(reg_addr(`REG_UART_TX), {24'($random(seed)), b0}, err, waits);
			check(err, 1'b0, "pslverr on TX write");
			apb_write(reg_addr(`REG_UART_TX), {24'($random(seed)), b1}, err, waits);
			check(waits != 0, 1'b1, "wait states on TX write while busy");
			recv_byte(got);
			check(got, b0, "first loopback byte");
			recv_byte(got);
			check(got, b1, "second loopback byte");
		end
		apb_read(reg_addr(`REG_UART_RX), rd, err);
		check(err, 1'b1, "pslverr on RX read after drain");

		$display("*** PASSED ***");
		$finish;
	end

endmodule

// File: mmio_props.sv
// MMIO bus and strobe checks
`timescale 1ns/1ns
`include "mmio_macros.svh"

module mmio_props (
	input logic             Clock,
	input logic             rst_n,
	input logic             psel,
	input logic             penable,
	input logic             pwrite,
	input mmio_pkg::word_t  paddr,
	input logic             pready,
	input logic             le_x0_valid,
	input logic             le_y0_valid,
	input logic             le_x1_valid,
	input logic             le_y1_valid,
	input logic             le_trigger,
	input logic             le_color_valid,
	input logic             fill_valid
);
	logic [3:0] coords;
	logic [5:0] strobes;
	int unsigned fail_count = 0;

	assign coords = {le_y1_valid, le_x1_valid, le_y0_valid, le_x0_valid};
	assign strobes = {fill_valid, le_color_valid, coords};

	a_one_coord: assert property (@(posedge Clock) disable iff (!rst_n) $onehot0(coords))
		else
		begin
			$error("more than one coordinate strobe high");
			fail_count++;
		end

	a_trigger: assert property (@(posedge Clock) disable iff (!rst_n) le_trigger |-> |coords)
		else
		begin
			$error("le_trigger without a coordinate strobe");
			fail_count++;
		end

	// No strobe may be high on two edges in a row
	a_pulse: assert property (@(posedge Clock) disable iff (!rst_n)
		(strobes & $past(strobes)) == 6'd0)
		else
		begin
			$error("command strobe longer than one cycle");
			fail_count++;
		end

	a_pready: assert property (@(posedge Clock) disable iff (!rst_n)
		psel && penable && !(pwrite && paddr[7:0] == `REG_UART_TX) |-> pready)
		else
		begin
			$error("pready low outside a TX write");
			fail_count++;
		end

endmodule

bind mmio_top mmio_props mmio_props_i (.*);

// File: mmio_top.sv
// Memory-mapped I/O top level
`timescale 1ns/1ns

module mmio_top (
	input  logic                Clock,
	input  logic                rst_n,
	input  logic                psel,
	input  logic                penable,
	input  logic                pwrite,
	input  mmio_pkg::word_t     paddr,
	input  mmio_pkg::word_t     pwdata,
	output mmio_pkg::word_t     prdata,
	output logic                pready,
	output logic                pslverr,
	input  logic                stall,
	input  logic                line_ready,
	input  logic                uart_sin,
	output logic                uart_sout,
	output mmio_pkg::point_t    le_point,
	output mmio_pkg::color_t    le_color,
	output logic                le_color_valid,
	output logic                le_x0_valid,
	output logic                le_y0_valid,
	output logic                le_x1_valid,
	output logic                le_y1_valid,
	output logic                le_trigger,
	output mmio_pkg::color_t    fill_color,
	output logic                fill_valid
);

	uart_if uart_bus ();

	io_regs io_regs_i (
		.Clock, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr, .stall, .line_ready,
		.le_point, .le_color, .le_color_valid,
		.le_x0_valid, .le_y0_valid, .le_x1_valid, .le_y1_valid,
		.le_trigger, .fill_color, .fill_valid,
		.u(uart_bus.regs)
	);

	uart uart_i (.Clock, .rst_n, .sin(uart_sin), .sout(uart_sout), .u(uart_bus.port));

endmodule

// File: io_regs.sv
// APB register block for soft processor I/O
`timescale 1ns/1ns
`include "mmio_macros.svh"

module io_regs (
	input  logic                Clock,
	input  logic                rst_n,
	input  logic                psel,
	input  logic                penable,
	input  logic                pwrite,
	input  mmio_pkg::word_t     paddr,
	input  mmio_pkg::word_t     pwdata,
	output mmio_pkg::word_t     prdata,
	output logic                pready,
	output logic                pslverr,
	input  logic                stall,
	input  logic                line_ready,
	output mmio_pkg::point_t    le_point,
	output mmio_pkg::color_t    le_color,
	output logic                le_color_valid,
	output logic                le_x0_valid,
	output logic                le_y0_valid,
	output logic                le_x1_valid,
	output logic                le_y1_valid,
	output logic                le_trigger,
	output mmio_pkg::color_t    fill_color,
	output logic                fill_valid,
	uart_if.regs                u
);
	import mmio_pkg::*;

	localparam word_t BASE = `IO_BASE;

	logic [7:0] offset;
	logic sel, defined, err, wr_done;
	logic rx_hit, tx_hit, clr_hit, fill_hit, color_hit, go_hit;
	logic [3:0] coord_hit;
	logic [3:0] coord_stb;
	word_t rd_data;
	word_t cycles, instrs;

	assign offset = paddr[7:0];
	assign sel = psel && penable && (paddr[31:8] == BASE[31:8]);

	// ----------------------------------------
	// Address decode and read mux
	// ----------------------------------------
	always_comb
	begin
		defined = 1'b1;
		rd_data = '0;
		rx_hit = 1'b0;
		tx_hit = 1'b0;
		clr_hit = 1'b0;
		fill_hit = 1'b0;
		color_hit = 1'b0;
		go_hit = 1'b0;
		coord_hit = '0;
		case (offset)
			`REG_UART_STAT: rd_data = {30'd0, u.rx_valid, u.tx_ready};
			`REG_UART_RX:
			begin
				rx_hit = 1'b1;
				rd_data = {24'd0, u.rx_data};
			end
			`REG_UART_TX: tx_hit = 1'b1;
			`REG_CYCLES: rd_data = cycles;
			`REG_INSTR: rd_data = instrs;
			`REG_CNT_CLR: clr_hit = 1'b1;
			`REG_FILL:
			begin
				fill_hit = 1'b1;
				rd_data = {8'd0, fill_color};
			end
			`REG_LINE_STAT: rd_data = {31'd0, line_ready};
			`REG_LE_COLOR:
			begin
				color_hit = 1'b1;
				rd_data = {8'd0, le_color};
			end
			// Offset bits 3:2 pick the coordinate
			`REG_X0, `REG_Y0, `REG_X1, `REG_Y1:
			begin
				coord_hit = 4'b0001 << offset[3:2];
				rd_data = {22'd0, le_point};
			end
			`REG_X0_GO, `REG_Y0_GO, `REG_X1_GO, `REG_Y1_GO:
			begin
				coord_hit = 4'b0001 << offset[3:2];
				go_hit = 1'b1;
				rd_data = {22'd0, le_point};
			end
			default: defined = 1'b0;
		endcase
	end

	// ----------------------------------------
	// APB response and UART handshakes
	// ----------------------------------------
	assign err = !(sel && defined) || (rx_hit && !pwrite && !u.rx_valid);
	assign pslverr = psel && penable && err;
	assign prdata = (psel && penable && !err) ? rd_data : '0;

	// TX write waits until the UART takes the byte
	assign pready = !(sel && pwrite && tx_hit && !u.tx_ready);
	assign u.tx_valid = sel && pwrite && tx_hit;
	assign u.tx_data = pwdata[7:0];
	assign u.rx_ready = sel && !pwrite && rx_hit && u.rx_valid;

	assign wr_done = sel && defined && pwrite && pready;

	// ----------------------------------------
	// Performance counters
	// ----------------------------------------
	always_ff @(posedge Clock)
	begin
		if (!rst_n || (wr_done && clr_hit))
		begin
			cycles <= '0;
			instrs <= '0;
		end
		else
		begin
			cycles <= cycles + 32'd1;
			if (!stall)
				instrs <= instrs + 32'd1;
		end
	end

	// ----------------------------------------
	// Command strobes, one cycle after the write
	// ----------------------------------------
	always_ff @(posedge Clock)
	begin
		if (!rst_n)
		begin
			coord_stb <= '0;
			le_trigger <= 1'b0;
			le_color_valid <= 1'b0;
			fill_valid <= 1'b0;
		end
		else
		begin
			coord_stb <= wr_done ? coord_hit : 4'b0000;
			le_trigger <= wr_done && go_hit;
			le_color_valid <= wr_done && color_hit;
			fill_valid <= wr_done && fill_hit;
		end
	end

	// Command data holds until the next write
	always_ff @(posedge Clock)
	begin
		if (wr_done && |coord_hit)
			le_point <= pwdata[9:0];
		if (wr_done && color_hit)
			le_color <= pwdata[23:0];
		if (wr_done && fill_hit)
			fill_color <= pwdata[23:0];
	end

	assign le_x0_valid = coord_stb[0];
	assign le_y0_valid = coord_stb[1];
	assign le_x1_valid = coord_stb[2];
	assign le_y1_valid = coord_stb[3];

endmodule

// File: uart.sv
// 8N1 serial transmitter and receiver
`timescale 1ns/1ns
`include "mmio_macros.svh"

module uart (
	input  logic   Clock,
	input  logic   rst_n,
	input  logic   sin,
	output logic   sout,
	uart_if.port   u
);
	import mmio_pkg::*;

	localparam int BIT_W = $clog2(`UART_BIT_CYCLES);
	localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(`UART_BIT_CYCLES - 1);
	localparam logic [BIT_W-1:0] HALF_LAST = BIT_W'(`UART_BIT_CYCLES / 2 - 1);

	uart_tx_state_t tx_state;
	logic [BIT_W-1:0] tx_cnt;
	logic [2:0] tx_bit;
	byte_t tx_shift;
	logic tx_tick;

	uart_rx_state_t rx_state;
	logic [BIT_W-1:0] rx_cnt;
	logic [2:0] rx_bit;
	byte_t rx_shift;
	logic rx_tick;
	logic sin_meta, sin_s;

	// ----------------------------------------
	// Transmitter
	// ----------------------------------------
	assign tx_tick = (tx_cnt == BIT_LAST);
	assign u.tx_ready = (tx_state == TX_IDLE);
	assign sout = (tx_state == TX_START) ? 1'b0 :
		(tx_state == TX_DATA) ? tx_shift[0] : 1'b1;

	always_ff @(posedge Clock)
	begin
		if (!rst_n)
		begin
			tx_state <= TX_IDLE;
			tx_cnt <= '0;
			tx_bit <= '0;
		end
		else if (tx_state == TX_IDLE)
		begin
			tx_cnt <= '0;
			tx_bit <= '0;
			if (u.tx_valid)
				tx_state <= TX_START;
		end
		else
		begin
			tx_cnt <= tx_tick ? '0 : tx_cnt + 1'b1;
			if (tx_tick)
			begin
				case (tx_state)
					TX_START: tx_state <= TX_DATA;
					TX_DATA:
					begin
						tx_bit <= tx_bit + 1'b1;
						if (tx_bit == 3'd7)
							tx_state <= TX_STOP;
					end
					default: tx_state <= TX_IDLE;
				endcase
			end
		end
	end

	// Shift out LSB first
	always_ff @(posedge Clock)
	begin
		if (u.tx_valid && u.tx_ready)
			tx_shift <= u.tx_data;
		else if (tx_state == TX_DATA && tx_tick)
			tx_shift <= {1'b0, tx_shift[7:1]};
	end

	// ----------------------------------------
	// Receiver
	// ----------------------------------------
	assign rx_tick = (rx_cnt == BIT_LAST);

	always_ff @(posedge Clock)
	begin
		if (!rst_n)
		begin
			sin_meta <= 1'b1;
			sin_s <= 1'b1;
			rx_state <= RX_IDLE;
			rx_cnt <= '0;
			rx_bit <= '0;
			u.rx_valid <= 1'b0;
		end
		else
		begin
			sin_meta <= sin;
			sin_s <= sin_meta;
			if (u.rx_ready)
				u.rx_valid <= 1'b0;
			case (rx_state)
				RX_IDLE:
				begin
					rx_cnt <= '0;
					rx_bit <= '0;
					if (!sin_s)
						rx_state <= RX_START;
				end
				RX_START:
				begin
					// Recheck at mid start bit, drop glitches
					rx_cnt <= (rx_cnt == HALF_LAST) ? '0 : rx_cnt + 1'b1;
					if (rx_cnt == HALF_LAST)
						rx_state <= sin_s ? RX_IDLE : RX_DATA;
				end
				RX_DATA:
				begin
					rx_cnt <= rx_tick ? '0 : rx_cnt + 1'b1;
					if (rx_tick)
					begin
						rx_bit <= rx_bit + 1'b1;
						if (rx_bit == 3'd7)
							rx_state <= RX_STOP;
					end
				end
				default:
				begin
					rx_cnt <= rx_tick ? '0 : rx_cnt + 1'b1;
					if (rx_tick)
					begin
						rx_state <= RX_IDLE;
						if (sin_s)
							u.rx_valid <= 1'b1;
					end
				end
			endcase
		end
	end

	always_ff @(posedge Clock)
	begin
		if (rx_state == RX_DATA && rx_tick)
			rx_shift <= {sin_s, rx_shift[7:1]};
		// Unread byte gets overwritten
		if (rx_state == RX_STOP && rx_tick && sin_s)
			u.rx_data <= rx_shift;
	end

endmodule

// File: uart_if.sv
// Register block to UART byte streams
`timescale 1ns/1ns

interface uart_if;
	import mmio_pkg::*;

	byte_t tx_data;
	logic  tx_valid;
	logic  tx_ready;
	byte_t rx_data;
	logic  rx_valid;
	logic  rx_ready;

	modport regs (output tx_data, output tx_valid, input tx_ready,
		input rx_data, input rx_valid, output rx_ready);

	modport port (input tx_data, input tx_valid, output tx_ready,
		output rx_data, output rx_valid, input rx_ready);

endinterface

// File: mmio_pkg.sv
// MMIO shared types
package mmio_pkg;

	typedef logic [31:0] word_t;
	typedef logic [7:0]  byte_t;
	typedef logic [9:0]  point_t;
	typedef logic [23:0] color_t;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} uart_tx_state_t;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} uart_rx_state_t;

endpackage

// File: mmio_macros.svh
// MMIO address map and UART timing
`ifndef MMIO_MACROS_SVH
`define MMIO_MACROS_SVH

// Block select, upper 24 address bits
`define IO_BASE         32'h8000_0000

// UART and performance counters
`define REG_UART_STAT   8'h00
`define REG_UART_RX     8'h04
`define REG_UART_TX     8'h08
`define REG_CYCLES      8'h10
`define REG_INSTR       8'h14
`define REG_CNT_CLR     8'h18

// Fill and line engine
`define REG_FILL        8'h20
`define REG_LINE_STAT   8'h24
`define REG_LE_COLOR    8'h28
`define REG_X0          8'h30
`define REG_Y0          8'h34
`define REG_X1          8'h38
`define REG_Y1          8'h3C
`define REG_X0_GO       8'h40
`define REG_Y0_GO       8'h44
`define REG_X1_GO       8'h48
`define REG_Y1_GO       8'h4C

`define UART_BIT_CYCLES 8

`endif
